// File: hps_cmd_framer.sv
// host link frame tracker
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_framer (
	input wire logic clk_sys,
	input wire logic reset,
	input wire hps_link_pkg::link_in_t link_in,
	output hps_link_pkg::link_word_t lw
);

	logic frame_en;
	logic frame_en_d;
	logic stb;
	logic [hps_link_pkg::word_w-1:0] cmd_q;
	logic [hps_link_pkg::cnt_w-1:0] idx_q;

	// a frame is open while either enable bit is set
	assign frame_en = |link_in.enable;
	assign stb = frame_en & link_in.strobe;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			frame_en_d <= 1'b0;
			cmd_q <= '0;
			idx_q <= '0;
		end else begin
			frame_en_d <= frame_en;
			if (!frame_en) begin
				idx_q <= '0;
			end else if (stb) begin
				if (idx_q == '0)
					cmd_q <= link_in.din;
				// hold at all ones on long frames
				if (!(&idx_q))
					idx_q <= idx_q + 1'b1;
			end
		end
	end

	// cmd stays latched after the frame so done still names it
	assign lw = '{
		cmd:     cmd_q,
		idx:     idx_q,
		data:    link_in.din,
		cmd_stb: stb & (idx_q == '0),
		dat_stb: stb & (idx_q != '0),
		done:    frame_en_d & ~frame_en
	};

	a_no_stb_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!frame_en |-> !(lw.cmd_stb || lw.dat_stb));

	// counter sticks at the top until the frame closes
	a_idx_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
		(frame_en && (&idx_q)) |=> (&idx_q));

endmodule

`default_nettype wire

// File: hps_file_loader.sv
// file download to the core
`timescale 1ns/1ps
`default_nettype none

module hps_file_loader (
	input wire logic clk_sys,
	input wire logic reset,
	input wire hps_link_pkg::link_word_t lw,
	output hps_link_pkg::ioctl_t ioctl
);

	logic [26:0] addr_q;
	logic wr_d;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl <= '0;
			addr_q <= '0;
			wr_d <= 1'b0;
		end else begin
			// write strobe trails the data word by one extra cycle
			ioctl.wr <= wr_d;
			wr_d <= 1'b0;
			if (lw.dat_stb) begin
				case (lw.cmd)
					hps_link_pkg::cmd_file_info: begin
						// extension arrives high half first
						if (lw.idx == 1)
							ioctl.file_ext[31:16] <= lw.data;
						else if (lw.idx == 2)
							ioctl.file_ext[15:0] <= lw.data;
					end
					hps_link_pkg::cmd_file_index: begin
						ioctl.index <= lw.data[7:0];
					end
					hps_link_pkg::cmd_file_tx: begin
						if (lw.data[7:0] != 8'h00) begin
							addr_q <= '0;
							ioctl.download <= 1'b1;
						end else begin
							// leave the byte count on addr
							ioctl.addr <= addr_q;
							ioctl.download <= 1'b0;
						end
					end
					hps_link_pkg::cmd_file_dat: begin
						ioctl.addr <= addr_q;
						ioctl.dout <= lw.data[7:0];
						wr_d <= 1'b1;
						addr_q <= addr_q + 27'd1;
					end
					default: ;
				endcase
			end
		end
	end

	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl.wr |=> !ioctl.wr);

endmodule

`default_nettype wire

// File: hps_link.f
hps_link_pkg.sv
hps_cmd_framer.sv
hps_user_regs.sv
hps_ps2_key.sv
hps_file_loader.sv
hps_link_top.sv
tb_hps_link.sv

// File: hps_link_patterns.txt
# name cmd words d0 d1 d2 d3 d4 d5 d6 d7 check sel expected (words and sel decimal, rest hex)
# core loads status_in from d3..d0 and the menu mask from d4; dat expects writes from address sel
cfg_a       0001 1 A5E6 0000 0000 0000 0000 0000 0000 0000 cfg    0 0402
joy0        0002 2 1111 A000 0000 0000 0000 0000 0000 0000 joy    0 A0001111
joy1        0003 2 2222 B001 0000 0000 0000 0000 0000 0000 joy    1 B0012222
joy2        0010 2 3333 C002 0000 0000 0000 0000 0000 0000 joy    2 C0023333
joy3        0011 2 4444 D003 0000 0000 0000 0000 0000 0000 joy    3 D0034444
joy4        0012 2 5555 E004 0000 0000 0000 0000 0000 0000 joy    4 E0045555
joy5        0013 2 6666 F005 0000 0000 0000 0000 0000 0000 joy    5 F0056666
joy2_low    0010 1 7777 0000 0000 0000 0000 0000 0000 0000 joy    2 C0027777
joy0_keep   0000 0 0000 0000 0000 0000 0000 0000 0000 0000 joy    0 A0001111
stat_w      001E 4 1234 5678 9ABC DEF0 0000 0000 0000 0000 status 0 DEF09ABC56781234
core_a      0000 0 0BAD F00D CAFE BEEF 5A3C 0000 0000 0000 core   0 0
sreq_tag    0029 4 0000 0000 0000 0000 0000 0000 0000 0000 word   0 A001
sreq_w1     0029 4 0000 0000 0000 0000 0000 0000 0000 0000 word   1 0BAD
sreq_w2     0029 4 0000 0000 0000 0000 0000 0000 0000 0000 word   2 F00D
sreq_w3     0029 4 0000 0000 0000 0000 0000 0000 0000 0000 word   3 CAFE
sreq_w4     0029 4 0000 0000 0000 0000 0000 0000 0000 0000 word   4 BEEF
sreq_idle   0029 4 0000 0000 0000 0000 0000 0000 0000 0000 word   9 0000
mmask       002E 1 0000 0000 0000 0000 0000 0000 0000 0000 word   1 5A3C
mmask_w2    002E 2 0000 0000 0000 0000 0000 0000 0000 0000 word   2 0000
kbd_make    0005 1 001C 0000 0000 0000 0000 0000 0000 0000 key    0 61C
kbd_break   0005 2 00F0 001C 0000 0000 0000 0000 0000 0000 key    0 01C
kbd_ext     0005 2 00E0 0075 0000 0000 0000 0000 0000 0000 key    0 775
kbd_prn     0005 4 00E0 0012 00E0 007C 0000 0000 0000 0000 key    0 37C
kbd_prn_rel 0005 6 00E0 00F0 007C 00E0 00F0 0012 0000 0000 key    0 57C
kbd_skip    0005 2 FF00 001C 0000 0000 0000 0000 0000 0000 key    0 57C
kbd_after   0005 1 0029 0000 0000 0000 0000 0000 0000 0000 key    0 229
dl_index    0055 1 0007 0000 0000 0000 0000 0000 0000 0000 none   0 0
dl_info     0056 2 4249 4E00 0000 0000 0000 0000 0000 0000 none   0 0
dl_start    0053 1 0001 0000 0000 0000 0000 0000 0000 0000 ioctl  0 10700000000042494E00
dl_dat_a    0054 3 0011 0022 0033 0000 0000 0000 0000 0000 dat    0 0
dl_dat_b    0054 2 00A4 01B5 0000 0000 0000 0000 0000 0000 dat    3 0
dl_stop     0053 1 0000 0000 0000 0000 0000 0000 0000 0000 ioctl  0 0070000005B542494E00

// File: hps_link_pkg.sv
// host link shared definitions
`default_nettype none

package hps_link_pkg;

	////////////////////////////////
	// link geometry
	////////////////////////////////
	localparam int word_w = 16;
	// word counter saturates at all ones
	localparam int cnt_w = 9;
	localparam int joy_num = 6;

	////////////////////////////////
	// command codes
	////////////////////////////////
	localparam logic [word_w-1:0] cmd_cfg = 16'h0001;
	// joysticks 0 to 5, index 0 in the lowest word
	localparam logic [joy_num-1:0][word_w-1:0] cmd_joy = {
		16'h0013, 16'h0012, 16'h0011, 16'h0010, 16'h0003, 16'h0002
	};
	localparam logic [word_w-1:0] cmd_kbd = 16'h0005;
	localparam logic [word_w-1:0] cmd_status = 16'h001E;
	localparam logic [word_w-1:0] cmd_status_req = 16'h0029;
	localparam logic [word_w-1:0] cmd_menumask = 16'h002E;
	localparam logic [word_w-1:0] cmd_file_tx = 16'h0053;
	localparam logic [word_w-1:0] cmd_file_dat = 16'h0054;
	localparam logic [word_w-1:0] cmd_file_index = 16'h0055;
	localparam logic [word_w-1:0] cmd_file_info = 16'h0056;

	////////////////////////////////
	// keyboard bytes and sequences
	////////////////////////////////
	localparam logic [7:0] kbd_skip = 8'hFF;
	localparam logic [7:0] kbd_release = 8'hF0;
	localparam logic [7:0] kbd_ext = 8'hE0;
	localparam logic [31:0] prn_press = 32'hE012E07C;
	localparam logic [31:0] prn_release = 32'h7CE0F012;
	localparam logic [31:0] pause_press = 32'hF014F077;
	// pressed, extended and code for the sequences above
	localparam logic [9:0] prn_press_code = 10'h37C;
	localparam logic [9:0] prn_release_code = 10'h17C;
	localparam logic [9:0] pause_press_code = 10'h377;

	// high nibble of the status request flag word
	localparam logic [3:0] status_req_tag = 4'hA;

	////////////////////////////////
	// bundles
	////////////////////////////////
	typedef struct packed {
		logic [1:0] enable;
		logic strobe;
		logic [word_w-1:0] din;
	} link_in_t;

	typedef struct packed {
		logic [word_w-1:0] cmd;
		logic [cnt_w-1:0] idx;
		logic [word_w-1:0] data;
		logic cmd_stb;
		logic dat_stb;
		logic done;
	} link_word_t;

	typedef struct packed {
		logic toggle;
		logic pressed;
		logic extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic download;
		logic [7:0] index;
		logic wr;
		logic [26:0] addr;
		logic [7:0] dout;
		logic [31:0] file_ext;
	} ioctl_t;

	typedef logic [joy_num-1:0][31:0] joy_set_t;

endpackage

`default_nettype wire

// File: hps_link_top.sv
// host command link top
`timescale 1ns/1ps
`default_nettype none

module hps_link_top (
	input wire logic clk_sys,
	input wire logic reset,

	// host side
	input wire hps_link_pkg::link_in_t link_in,
	output logic [hps_link_pkg::word_w-1:0] io_dout,
	output logic io_wait,

	// configuration
	output logic [1:0] buttons,
	output logic forced_scandoubler,
	output logic direct_video,

	output hps_link_pkg::joy_set_t joystick,

	// status exchange with the core
	output logic [63:0] status,
	input wire logic [63:0] status_in,
	input wire logic status_set,
	input wire logic [15:0] status_menumask,

	output hps_link_pkg::ps2_key_t ps2_key,

	// download to the core
	output hps_link_pkg::ioctl_t ioctl,
	input wire logic ioctl_wait
);

	hps_link_pkg::link_word_t lw;

	// no back-pressure, the host only sees the core's wait
	assign io_wait = ioctl_wait;

	hps_cmd_framer u_framer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.link_in (link_in),
		.lw      (lw)
	);

	hps_user_regs u_user_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.lw                 (lw),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick           (joystick),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask)
	);

	hps_ps2_key u_ps2_key (
		.clk_sys (clk_sys),
		.reset   (reset),
		.lw      (lw),
		.ps2_key (ps2_key)
	);

	hps_file_loader u_file_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.lw      (lw),
		.ioctl   (ioctl)
	);

endmodule

`default_nettype wire

// File: hps_ps2_key.sv
// keyboard scan-code decoder
`timescale 1ns/1ps
`default_nettype none

module hps_ps2_key (
	input wire logic clk_sys,
	input wire logic reset,
	input wire hps_link_pkg::link_word_t lw,
	output hps_link_pkg::ps2_key_t ps2_key
);

	logic [31:0] raw;
	logic skip;
	logic kbd_frame;
	logic pressed;
	logic extended;
	logic [9:0] key_bits;

	assign kbd_frame = (lw.cmd == hps_link_pkg::cmd_kbd);

	// break codes put F0 between the prefix and the code
	always_comb begin
		pressed = (raw[15:8] != hps_link_pkg::kbd_release);
		if (pressed)
			extended = (raw[15:8] == hps_link_pkg::kbd_ext);
		else
			extended = (raw[23:16] == hps_link_pkg::kbd_ext);
		key_bits = {pressed, extended, raw[7:0]};
		if (raw == hps_link_pkg::prn_press)
			key_bits = hps_link_pkg::prn_press_code;
		if (raw == hps_link_pkg::prn_release)
			key_bits = hps_link_pkg::prn_release_code;
		if (raw == hps_link_pkg::pause_press)
			key_bits = hps_link_pkg::pause_press_code;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			raw <= '0;
			skip <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (lw.cmd_stb && lw.data == hps_link_pkg::cmd_kbd) begin
				raw <= '0;
				skip <= 1'b0;
			end else if (lw.dat_stb && kbd_frame) begin
				// FF in the high byte drops the rest of the frame
				if (lw.data[15:8] == hps_link_pkg::kbd_skip)
					skip <= 1'b1;
				else if (!skip)
					raw <= {raw[23:0], lw.data[7:0]};
			end
			if (lw.done && kbd_frame && !skip)
				ps2_key <= {~ps2_key.toggle, key_bits};
		end
	end

	a_key_after_done: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(ps2_key) |-> $past(lw.done));

endmodule

`default_nettype wire

// File: hps_user_regs.sv
// configuration, joystick and status registers
`timescale 1ns/1ps
`default_nettype none

module hps_user_regs (
	input wire logic clk_sys,
	input wire logic reset,
	input wire hps_link_pkg::link_word_t lw,
	output logic [hps_link_pkg::word_w-1:0] io_dout,
	output logic [1:0] buttons,
	output logic forced_scandoubler,
	output logic direct_video,
	output hps_link_pkg::joy_set_t joystick,
	output logic [63:0] status,
	input wire logic [63:0] status_in,
	input wire logic status_set,
	input wire logic [15:0] status_menumask
);

	logic [hps_link_pkg::word_w-1:0] cfg;
	logic [hps_link_pkg::word_w-1:0] resp;
	logic [63:0] status_req;
	logic [3:0] req_cnt;
	logic status_set_d;
	logic quad_word;
	logic [1:0] seg;

	assign buttons = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video = cfg[10];

	// data words 1 to 4 map onto the four 16-bit quarters
	assign quad_word = (lw.idx >= 1) && (lw.idx <= 4);
	assign seg = lw.idx[1:0] - 2'd1;

	//////////////////////////////
	// host writes
	//////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg <= '0;
			joystick <= '0;
			status <= '0;
		end else if (lw.dat_stb) begin
			if (lw.cmd == hps_link_pkg::cmd_cfg)
				cfg <= lw.data;
			if (lw.cmd == hps_link_pkg::cmd_status && quad_word)
				status[{seg, 4'b0000} +: 16] <= lw.data;
			for (int i = 0; i < hps_link_pkg::joy_num; i++) begin
				if (lw.cmd == hps_link_pkg::cmd_joy[i]) begin
					// first word is the low half
					if (lw.idx == 1)
						joystick[i][15:0] <= lw.data;
					else
						joystick[i][31:16] <= lw.data;
				end
			end
		end
	end

	//////////////////////////////
	// core status request
	//////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_d <= 1'b0;
			req_cnt <= '0;
			status_req <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				req_cnt <= req_cnt + 4'd1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////
	// read back
	//////////////////////////////
	always_comb begin
		resp = '0;
		if (lw.cmd_stb) begin
			if (lw.data == hps_link_pkg::cmd_status_req)
				resp = {hps_link_pkg::status_req_tag, 8'h00, req_cnt};
		end else begin
			case (lw.cmd)
				hps_link_pkg::cmd_status_req: begin
					if (quad_word)
						resp = status_req[{seg, 4'b0000} +: 16];
				end
				hps_link_pkg::cmd_menumask: begin
					if (lw.idx == 1)
						resp = status_menumask;
				end
				default: resp = '0;
			endcase
		end
	end

	// every strobe reloads the response, frame end clears it
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			io_dout <= '0;
		else if (lw.done)
			io_dout <= '0;
		else if (lw.cmd_stb || lw.dat_stb)
			io_dout <= resp;
	end

	a_stb_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(lw.cmd_stb && lw.dat_stb));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the hps_link testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_hps_link \
	-f hps_link.f \
	-Mdir obj_dir

./obj_dir/Vtb_hps_link | tee sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb_hps_link.sv
// host link testbench
`timescale 1ns/1ps
`default_nettype none

module tb_hps_link;

	logic clk_sys;
	logic reset;
	hps_link_pkg::link_in_t link_in;
	logic [hps_link_pkg::word_w-1:0] io_dout;
	logic io_wait;
	logic [1:0] buttons;
	logic forced_scandoubler;
	logic direct_video;
	hps_link_pkg::joy_set_t joystick;
	logic [63:0] status;
	logic [63:0] status_in;
	logic status_set;
	logic [15:0] status_menumask;
	hps_link_pkg::ps2_key_t ps2_key;
	hps_link_pkg::ioctl_t ioctl;
	logic ioctl_wait;

	// fields of the current pattern line
	string name;
	string kind;
	logic [15:0] cmd;
	int n;
	logic [15:0] d [8];
	int sel;
	logic [79:0] exp_val;

	// io_dout after each strobe, slot 9 after the frame ends
	logic [15:0] resp_got [10];
	hps_link_pkg::ioctl_t wr_log [$];
	string pattern_lines [$];

	integer seed;
	int errors;
	int checks;
	int n_lines;
	bit lines_known;

	hps_link_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// a write pulse lasts one cycle, so one falling edge sees it
	always @(negedge clk_sys) begin
		if (ioctl.wr)
			wr_log.push_back(ioctl);
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_word(input string test, input logic [hps_link_pkg::word_w-1:0] expected,
			input logic [hps_link_pkg::word_w-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", test, expected, actual);
		end
	endtask

	task automatic check_joy(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", test, expected, actual);
		end
	endtask

	task automatic check_status(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", test, expected, actual);
		end
	endtask

	task automatic check_key(input string test, input hps_link_pkg::ps2_key_t expected,
			input hps_link_pkg::ps2_key_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", test, expected, actual);
		end
	endtask

	task automatic check_ioctl(input string test, input hps_link_pkg::ioctl_t expected,
			input hps_link_pkg::ioctl_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", test, expected, actual);
		end
	endtask

	task automatic check_wait(input string test, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %b, got %b", test, expected, actual);
		end
	endtask

	//////////////////////////////
	// host side driver
	//////////////////////////////
	task send_frame();
		int gaps;
		@(negedge clk_sys);
		wr_log.delete();
		foreach (resp_got[i])
			resp_got[i] = 'x;
		// flip the core's wait line on every frame
		ioctl_wait = ~ioctl_wait;
		link_in.enable = 2'(({$random(seed)} % 3) + 1);
		@(negedge clk_sys);
		for (int k = 0; k <= n; k++) begin
			link_in.strobe = 1'b1;
			if (k == 0)
				link_in.din = cmd;
			else
				link_in.din = d[k-1];
			@(negedge clk_sys);
			link_in.strobe = 1'b0;
			resp_got[k] = io_dout;
			gaps = {$random(seed)} % 4;
			repeat (gaps + 1) @(negedge clk_sys);
		end
		link_in.enable = 2'b00;
		// room for done, the key update and the last write pulse
		repeat (4) @(negedge clk_sys);
		resp_got[9] = io_dout;
	endtask

	// one write per data word, addresses counting up from sel
	task check_writes();
		hps_link_pkg::ioctl_t exp_w;
		hps_link_pkg::ioctl_t got_w;
		check_word(name, 16'(n), 16'(wr_log.size()));
		for (int i = 0; i < n && i < wr_log.size(); i++) begin
			exp_w = '0;
			exp_w.wr = 1'b1;
			exp_w.addr = 27'(sel + i);
			exp_w.dout = d[i][7:0];
			got_w = '0;
			got_w.wr = wr_log[i].wr;
			got_w.addr = wr_log[i].addr;
			got_w.dout = wr_log[i].dout;
			check_ioctl(name, exp_w, got_w);
		end
	endtask

	task run_line();
		if (kind == "core") begin
			@(negedge clk_sys);
			status_in = {d[3], d[2], d[1], d[0]};
			status_menumask = d[4];
			status_set = 1'b1;
			repeat (2) @(negedge clk_sys);
			status_set = 1'b0;
			@(negedge clk_sys);
		end else begin
			send_frame();
			check_wait(name, ioctl_wait, io_wait);
			if (kind == "cfg")
				check_word(name, exp_val[15:0],
					{5'b0, direct_video, 5'b0, forced_scandoubler, 2'b0, buttons});
			else if (kind == "word")
				check_word(name, exp_val[15:0], resp_got[sel]);
			else if (kind == "joy")
				check_joy(name, exp_val[31:0], joystick[sel]);
			else if (kind == "status")
				check_status(name, exp_val[63:0], status);
			else if (kind == "key")
				check_key(name, exp_val[10:0], ps2_key);
			else if (kind == "ioctl")
				check_ioctl(name, exp_val[76:0], ioctl);
			else if (kind == "dat")
				check_writes();
			else if (kind != "none") begin
				errors++;
				$display("test %s has an unknown check kind %s", name, kind);
			end
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		int fd;
		int items;
		string line;
		reset = 1'b1;
		link_in = '0;
		status_in = '0;
		status_set = 1'b0;
		status_menumask = '0;
		ioctl_wait = 1'b0;
		seed = 32'h07339cb2;
		errors = 0;
		checks = 0;
		fd = $fopen("hps_link_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open hps_link_patterns.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					pattern_lines.push_back(line);
			end
			$fclose(fd);
		end
		n_lines = pattern_lines.size();
		lines_known = 1'b1;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		foreach (pattern_lines[i]) begin
			items = $sscanf(pattern_lines[i], "%s %h %d %h %h %h %h %h %h %h %h %s %d %h",
				name, cmd, n, d[0], d[1], d[2], d[3], d[4], d[5], d[6], d[7],
				kind, sel, exp_val);
			if (items != 14) begin
				errors++;
				$display("pattern line %0d could not be parsed", i + 1);
			end else
				run_line();
		end
		if (checks == 0) begin
			errors++;
			$display("no checks were run");
		end
		repeat (2) @(negedge clk_sys);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// run length follows the number of pattern lines
	initial begin
		wait (lines_known);
		repeat (n_lines * 40 + 1000) @(posedge clk_sys);
		$display("timeout: the pattern run did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
